/* sim.f */
design/frontend_pkg.sv
design/prefetch_fetch.sv
design/byte_fifo.sv
design/immediate_reader.sv
design/prefetch_frontend.sv
sim/tb_clock.sv
sim/tb_prefetch_frontend.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_prefetch_frontend

out=$(./obj_dir/Vtb_prefetch_frontend)
echo "$out"

# A missing pass line makes grep, and so the script, fail
echo "$out" | grep -q "^Regression passed$"

/* sim/tb_prefetch_frontend.sv */
`timescale 1ns/1ns

module tb_prefetch_frontend;
    import frontend_pkg::*;

    // Bytes requested over all reads size the watchdog
    localparam int planned_bytes = 41;
    localparam int watchdog_cycles = planned_bytes * 200 + 1000;

    logic clk;
    logic arst_n;
    logic load_new_ip;
    cs_ip_t new_target;
    logic [word_width-1:0] instr_m_data_in;
    logic instr_m_ack;
    logic immed_start;
    logic immed_is_8bit;
    logic [phys_addr_width-1:1] instr_m_addr;
    logic instr_m_access;
    logic busy;
    immed_result_t result;

    logic [15:0] exp_values [$];
    string exp_names [$];
    int issued = 0;
    int checked = 0;
    int pass_count = 0;
    int fail_count = 0;
    int ack_count = 0;
    logic [31:0] mem_seed = 32'd12;
    logic [31:0] stim_seed = 32'd12;
    logic [15:0] cur_cs;
    logic [15:0] cur_ip;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    prefetch_frontend u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .load_new_ip     (load_new_ip),
        .new_target      (new_target),
        .instr_m_data_in (instr_m_data_in),
        .instr_m_ack     (instr_m_ack),
        .immed_start     (immed_start),
        .immed_is_8bit   (immed_is_8bit),
        .instr_m_addr    (instr_m_addr),
        .instr_m_access  (instr_m_access),
        .busy            (busy),
        .result          (result)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Every address bit flips some bit of the stored byte
    function automatic logic [7:0] mem_byte(input logic [19:0] p);
        return p[7:0] ^ p[15:8] ^ {4'h0, p[19:16]};
    endfunction

    function automatic logic [15:0] expected_immediate(input logic [15:0] cs,
                                                       input logic [15:0] ip,
                                                       input int n);
        logic [15:0] value;
        logic [15:0] off;
        logic [19:0] p;
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            off = ip + 16'(i);
            p = 20'(cs) * 20'd16 + 20'(off);
            value[8*i +: 8] = mem_byte(p);
        end
        return value;
    endfunction

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    // Caller is already 1 ns past a rising edge
    task automatic pulse_redirect(input logic [15:0] cs, input logic [15:0] ip);
        new_target.cs = cs;
        new_target.ip = ip;
        load_new_ip = 1'b1;
        next_drive_point();
        load_new_ip = 1'b0;
        cur_cs = cs;
        cur_ip = ip;
    endtask

    task automatic redirect(input logic [15:0] cs, input logic [15:0] ip);
        next_drive_point();
        pulse_redirect(cs, ip);
    endtask

    task automatic redirect_on_access(input logic [15:0] cs, input logic [15:0] ip);
        int waited;
        waited = 0;
        next_drive_point();
        while (!instr_m_access && waited < 20) begin
            next_drive_point();
            waited++;
        end
        pulse_redirect(cs, ip);
    endtask

    task automatic read_immediate(input string name, input bit is_8bit);
        int n;
        n = is_8bit ? 1 : 2;
        exp_names.push_back(name);
        exp_values.push_back(expected_immediate(cur_cs, cur_ip, n));
        issued++;
        next_drive_point();
        immed_start = 1'b1;
        immed_is_8bit = is_8bit;
        next_drive_point();
        immed_start = 1'b0;
        if (busy !== 1'b1) begin
            $display("Reader busy did not rise after the start of %s", name);
            fail_count++;
        end
        wait (checked == issued);
        cur_ip = cur_ip + 16'(n);
    endtask

    // Instruction bus memory with 0 to 3 cycles of ack delay
    initial begin
        int delay_left;
        bit counting;
        delay_left = 0;
        counting = 1'b0;
        instr_m_ack = 1'b0;
        instr_m_data_in = '0;
        forever begin
            next_drive_point();
            if (instr_m_ack) begin
                instr_m_ack = 1'b0;
                instr_m_data_in = '0;
            end else if (instr_m_access) begin
                if (!counting) begin
                    mem_seed = lcg_step(mem_seed);
                    delay_left = int'((mem_seed >> 16) % 4);
                    counting = 1'b1;
                end
                if (delay_left == 0) begin
                    instr_m_ack = 1'b1;
                    instr_m_data_in = {mem_byte({instr_m_addr, 1'b1}),
                                       mem_byte({instr_m_addr, 1'b0})};
                    counting = 1'b0;
                    ack_count++;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    // Result checker samples on the falling edge
    initial begin
        logic [15:0] exp_value;
        string name;
        forever begin
            @(negedge clk);
            if (result.complete) begin
                if (exp_values.size() == 0) begin
                    $display("Reader signalled complete with no read outstanding");
                    fail_count++;
                end else begin
                    exp_value = exp_values.pop_front();
                    name = exp_names.pop_front();
                    if (result.value !== exp_value) begin
                        $display("FAIL %s expected %04h actual %04h", name, exp_value,
                                 result.value);
                        fail_count++;
                    end else begin
                        $display("PASS %s value %04h", name, result.value);
                        pass_count++;
                    end
                    checked++;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, a read or bus access never finished",
                 watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int i;
        int waited;
        logic [15:0] cs_a;
        logic [15:0] cs_b;
        load_new_ip = 1'b0;
        new_target = '0;
        immed_start = 1'b0;
        immed_is_8bit = 1'b0;
        cur_cs = '0;
        cur_ip = '0;

        wait (arst_n);
        if (instr_m_access !== 1'b0 || busy !== 1'b0 || result.complete !== 1'b0) begin
            $display("FAIL reset_state expected 000 actual %b%b%b", instr_m_access, busy,
                     result.complete);
            fail_count++;
        end else begin
            $display("PASS reset_state");
            pass_count++;
        end

        waited = 0;
        while (!instr_m_access && waited < 10) begin
            next_drive_point();
            waited++;
        end
        if (!instr_m_access) begin
            $display("No bus access started after reset");
            fail_count++;
        end else if (instr_m_addr !== '0) begin
            $display("FAIL first_addr expected %05h actual %05h", 19'h0, instr_m_addr);
            fail_count++;
        end else begin
            $display("PASS first_addr");
            pass_count++;
        end

        redirect(16'h2000, 16'h0010);
        for (i = 0; i < 6; i++) begin
            read_immediate($sformatf("even_byte%0d", i), 1'b1);
        end
        read_immediate("word_aligned", 1'b0);
        read_immediate("byte_before_split", 1'b1);
        read_immediate("word_straddle", 1'b0);

        redirect(16'h1234, 16'h0101);
        read_immediate("odd_first_byte", 1'b1);
        read_immediate("odd_next_word", 1'b0);
        redirect(16'h0F00, 16'hFFFD);
        read_immediate("wrap_word0", 1'b0);
        read_immediate("wrap_word1", 1'b0);
        read_immediate("wrap_byte", 1'b1);

        // Redirects that land on an outstanding access and leftover bytes
        for (i = 0; i < 4; i++) begin
            stim_seed = lcg_step(stim_seed);
            cs_a = stim_seed[31:16];
            stim_seed = lcg_step(stim_seed);
            cs_b = stim_seed[31:16];
            redirect(cs_a, stim_seed[15:0]);
            read_immediate($sformatf("switch%0d_old", i), 1'b1);
            redirect_on_access(cs_b, stim_seed[15:0] ^ 16'h5a5a);
            read_immediate($sformatf("switch%0d_word", i), 1'b0);
            read_immediate($sformatf("switch%0d_byte", i), 1'b1);
        end

        // Let the FIFO fill and the bus go idle before counting
        repeat (40) @(posedge clk);
        #1;
        while (instr_m_access) begin
            next_drive_point();
        end
        ack_count = 0;
        pulse_redirect(16'h8000, 16'h0003);
        repeat (100) @(posedge clk);
        if (ack_count > 3) begin
            $display("FAIL ack_limit expected 3 actual %0d", ack_count);
            fail_count++;
        end else begin
            $display("PASS ack_limit acks %0d", ack_count);
            pass_count++;
        end
        read_immediate("full_word0", 1'b0);
        read_immediate("full_word1", 1'b0);
        read_immediate("full_word2", 1'b0);

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);
    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release 1 ns after the third rising edge
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* design/prefetch_frontend.sv */
`timescale 1ns/1ns

module prefetch_frontend (
    input  logic clk,
    input  logic arst_n,
    input  logic load_new_ip,
    input  frontend_pkg::cs_ip_t new_target,
    input  logic [frontend_pkg::word_width-1:0] instr_m_data_in,
    input  logic instr_m_ack,
    input  logic immed_start,
    input  logic immed_is_8bit,
    output logic [frontend_pkg::phys_addr_width-1:1] instr_m_addr,
    output logic instr_m_access,
    output logic busy,
    output frontend_pkg::immed_result_t result
);
    import frontend_pkg::*;

    fifo_wr_t fifo_wr;
    fifo_rd_t fifo_rd;
    logic fifo_flush;
    logic fifo_nearly_full_level;
    logic fifo_rd_en;

    prefetch_fetch u_fetch (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .load_new_ip            (load_new_ip),
        .new_target             (new_target),
        .fifo_nearly_full_level (fifo_nearly_full_level),
        .instr_m_data_in        (instr_m_data_in),
        .instr_m_ack            (instr_m_ack),
        .instr_m_addr           (instr_m_addr),
        .instr_m_access         (instr_m_access),
        .fifo_wr                (fifo_wr),
        .fifo_flush             (fifo_flush)
    );

    byte_fifo u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (fifo_flush),
        .wr          (fifo_wr),
        .rd_en       (fifo_rd_en),
        .rd          (fifo_rd),
        .nearly_full (fifo_nearly_full_level)
    );

    immediate_reader u_reader (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (immed_start),
        .is_8bit    (immed_is_8bit),
        .fifo_rd    (fifo_rd),
        .fifo_rd_en (fifo_rd_en),
        .busy       (busy),
        .result     (result)
    );

endmodule

/* design/immediate_reader.sv */
`timescale 1ns/1ns

module immediate_reader (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    input  logic is_8bit,
    input  frontend_pkg::fifo_rd_t fifo_rd,
    output logic fifo_rd_en,
    output logic busy,
    output frontend_pkg::immed_result_t result
);
    import frontend_pkg::*;

    logic need_two;
    logic have_low;
    logic complete;
    logic [word_width-1:0] value;
    logic last_byte;

    // Pop whenever a byte is waiting and bytes are still owed
    assign fifo_rd_en = busy && !fifo_rd.empty;
    assign last_byte = fifo_rd_en && (have_low || !need_two);

    assign result.complete = complete;
    assign result.value = value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            need_two <= 1'b0;
            have_low <= 1'b0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                need_two <= !is_8bit;
                have_low <= 1'b0;
            end else if (last_byte) begin
                busy <= 1'b0;
                complete <= 1'b1;
            end else if (fifo_rd_en) begin
                have_low <= 1'b1;
            end
        end
    end

    // Little endian, first byte low and upper byte zeroed
    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            if (have_low) begin
                value[word_width-1:byte_width] <= fifo_rd.data;
            end else begin
                value <= {{(word_width - byte_width){1'b0}}, fifo_rd.data};
            end
        end
    end

endmodule

/* design/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo (
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    input  frontend_pkg::fifo_wr_t wr,
    input  logic rd_en,
    output frontend_pkg::fifo_rd_t rd,
    output logic nearly_full
);
    import frontend_pkg::*;

    logic [byte_width-1:0] mem [fifo_depth];
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_count_width-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_pop = rd_en && (count != '0);
    // A pop in the same cycle frees a slot for the push
    assign do_push = wr.valid && ((count != fifo_count_width'(fifo_depth)) || do_pop);

    assign rd.empty = (count == '0);
    assign rd.data = mem[rd_ptr];
    assign nearly_full = (count >= fifo_count_width'(fifo_nearly_full));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem[wr_ptr] <= wr.data;
        end
    end

endmodule

/* design/prefetch_fetch.sv */
`timescale 1ns/1ns

module prefetch_fetch (
    input  logic clk,
    input  logic arst_n,
    input  logic load_new_ip,
    input  frontend_pkg::cs_ip_t new_target,
    input  logic fifo_nearly_full_level,
    input  logic [frontend_pkg::word_width-1:0] instr_m_data_in,
    input  logic instr_m_ack,
    output logic [frontend_pkg::phys_addr_width-1:1] instr_m_addr,
    output logic instr_m_access,
    output frontend_pkg::fifo_wr_t fifo_wr,
    output logic fifo_flush
);
    import frontend_pkg::*;

    cs_ip_t cs_ip;
    logic access_pending;
    logic discard;
    logic word_valid;
    logic [word_width-1:0] word_q;
    logic [phys_addr_width-1:0] phys_addr;
    logic start_access;
    logic take_word;

    // Segment times 16 plus offset, wraps at 1 MiB
    assign phys_addr = {cs_ip.cs, 4'b0000} + {4'b0000, cs_ip.ip};

    assign start_access = !access_pending && !word_valid &&
                          !fifo_nearly_full_level && !load_new_ip;

    // Returned data is dropped if a redirect hit before or during the ack
    assign take_word = access_pending && instr_m_ack && !discard && !load_new_ip;

    assign instr_m_access = access_pending;
    assign fifo_flush = load_new_ip;

    // IP parity selects the byte, so an odd IP skips the low byte
    assign fifo_wr.valid = word_valid;
    assign fifo_wr.data = cs_ip.ip[0] ? word_q[word_width-1:byte_width] :
                                        word_q[byte_width-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_ip <= '0;
            access_pending <= 1'b0;
            discard <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (load_new_ip) begin
                cs_ip <= new_target;
                word_valid <= 1'b0;
            end else if (word_valid) begin
                cs_ip.ip <= cs_ip.ip + 1'b1;
                // High byte is always the last of a word
                if (cs_ip.ip[0]) begin
                    word_valid <= 1'b0;
                end
            end else if (take_word) begin
                word_valid <= 1'b1;
            end

            if (access_pending) begin
                if (instr_m_ack) begin
                    access_pending <= 1'b0;
                    discard <= 1'b0;
                end else if (load_new_ip) begin
                    discard <= 1'b1;
                end
            end else if (start_access) begin
                access_pending <= 1'b1;
            end
        end
    end

    // Address held stable from access start until ack
    always_ff @(posedge clk) begin
        if (start_access) begin
            instr_m_addr <= phys_addr[phys_addr_width-1:1];
        end
        if (take_word) begin
            word_q <= instr_m_data_in;
        end
    end

endmodule

/* design/frontend_pkg.sv */
package frontend_pkg;

    // Bus and datapath widths
    localparam int phys_addr_width = 20;
    localparam int word_width = 16;
    localparam int byte_width = 8;

    // Prefetch FIFO sizing
    localparam int fifo_depth = 6;
    localparam int fifo_nearly_full = 5;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // Redirect target
    typedef struct packed {
        logic [word_width-1:0] cs;
        logic [word_width-1:0] ip;
    } cs_ip_t;

    // Push from the fetch stage
    typedef struct packed {
        logic valid;
        logic [byte_width-1:0] data;
    } fifo_wr_t;

    // FIFO head as seen by the reader
    typedef struct packed {
        logic empty;
        logic [byte_width-1:0] data;
    } fifo_rd_t;

    // Immediate reader result
    typedef struct packed {
        logic complete;
        logic [word_width-1:0] value;
    } immed_result_t;

endpackage
